/* exu.sv */
`timescale 1ns/1ps
`default_nettype none

module exu
    import rv_pkg::*;
(
    input  decode_t   dec,
    input  addr_t     pc,
    input  logic      inst_valid,
    output logic      rd_wen,
    output reg_addr_t rd_addr,
    output word_t     rd_data,
    output addr_t     next_pc
);

    word_t      alu_res;
    logic [4:0] shamt;
    addr_t      pc_plus4;

    assign shamt    = dec.src2[4:0];   // Shift amount is low 5 bits only
    assign pc_plus4 = pc + 32'd4;

    // ==================================================
    // ALU
    // ==================================================
    always_comb begin
        case (dec.alu_op)
            ALU_ADD:
                alu_res = dec.src1 + dec.src2;
            ALU_SUB:
                alu_res = dec.src1 - dec.src2;
            ALU_SLL:
                alu_res = dec.src1 << shamt;
            ALU_SLT:
                alu_res = {31'b0, $signed(dec.src1) < $signed(dec.src2)};
            ALU_SLTU:
                alu_res = {31'b0, dec.src1 < dec.src2};
            ALU_XOR:
                alu_res = dec.src1 ^ dec.src2;
            ALU_SRL:
                alu_res = dec.src1 >> shamt;
            ALU_SRA:
                alu_res = $signed(dec.src1) >>> shamt;
            ALU_OR:
                alu_res = dec.src1 | dec.src2;
            ALU_AND:
                alu_res = dec.src1 & dec.src2;
            default:
                alu_res = ZERO_WORD;
        endcase
    end

    // ==================================================
    // Write-back and next pc
    // ==================================================
    assign rd_wen  = dec.reg_wen & inst_valid;
    assign rd_addr = dec.rd;
    assign rd_data = dec.jump ? pc_plus4 : alu_res;          // Link address on jumps
    assign next_pc = dec.jump ? {alu_res[31:1], 1'b0} : pc_plus4;

endmodule

`default_nettype wire

/* idu.sv */
`timescale 1ns/1ps
`default_nettype none

module idu
    import rv_pkg::*;
(
    input  inst_t   inst,
    input  addr_t   pc,
    input  word_t   reg_rdata1,
    input  word_t   reg_rdata2,
    output decode_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7_bit5;
    logic       is_op;
    word_t      imm;
    word_t      src1;
    word_t      src2;
    alu_op_t    alu_op;
    logic       jump;
    logic       reg_wen;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign f7_bit5 = inst[30];      // SUB and SRA/SRAI
    assign is_op   = (opcode == OPC_OP);

    // ==================================================
    // Immediates
    // ==================================================
    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_JALR:
                imm = {{20{inst[31]}}, inst[31:20]};
            OPC_JAL:
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            OPC_LUI, OPC_AUIPC:
                imm = {inst[31:12], 12'b0};
            default:
                imm = ZERO_WORD;
        endcase
    end

    // ==================================================
    // Operand select
    // ==================================================
    always_comb begin
        case (opcode)
            OPC_AUIPC, OPC_JAL:           src1 = pc;
            OPC_JALR, OPC_OP_IMM, OPC_OP: src1 = reg_rdata1;
            default:                      src1 = ZERO_WORD;  // LUI adds to zero
        endcase
    end

    assign src2 = is_op ? reg_rdata2 : imm;

    // ==================================================
    // ALU operation and control flags
    // ==================================================
    always_comb begin
        alu_op = ALU_ADD;                // Jumps and U-types
        if (is_op || opcode == OPC_OP_IMM) begin
            case (funct3)
                F3_ADD_SUB: alu_op = (is_op && f7_bit5) ? ALU_SUB : ALU_ADD;
                F3_SLL:     alu_op = ALU_SLL;
                F3_SLT:     alu_op = ALU_SLT;
                F3_SLTU:    alu_op = ALU_SLTU;
                F3_XOR:     alu_op = ALU_XOR;
                F3_SRL_SRA: alu_op = f7_bit5 ? ALU_SRA : ALU_SRL;
                F3_OR:      alu_op = ALU_OR;
                F3_AND:     alu_op = ALU_AND;
            endcase
        end
    end

    assign jump = (opcode == OPC_JAL) || (opcode == OPC_JALR);

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_OP_IMM, OPC_OP:
                reg_wen = 1'b1;
            default:
                reg_wen = 1'b0;          // Unsupported opcode is a no-op
        endcase
    end

    assign dec = '{src1:    src1,
                   src2:    src2,
                   alu_op:  alu_op,
                   jump:    jump,
                   reg_wen: reg_wen,
                   rd:      inst[11:7]};

endmodule

`default_nettype wire

/* pc_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_reg
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  inst_valid,
    input  addr_t next_pc,
    output addr_t pc
);

    // ==================================================
    // Program counter
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;              // Fetch starts at address 0
        end else if (inst_valid) begin
            pc <= next_pc;
        end                        // Stall holds the current pc
    end

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile
    import rv_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [REG_COUNT];

    // ==================================================
    // Write port
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= ZERO_WORD;
            end
        end else if (wen && waddr != '0 && int'(waddr) < REG_COUNT) begin
            regs[waddr] <= wdata;          // x0 never written
        end
    end

    // ==================================================
    // Read ports
    // ==================================================
    // Indices past REG_COUNT read as zero, as x0 does
    assign rdata1 = (rs1 != '0 && int'(rs1) < REG_COUNT) ? regs[rs1] : ZERO_WORD;
    assign rdata2 = (rs2 != '0 && int'(rs2) < REG_COUNT) ? regs[rs2] : ZERO_WORD;

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic      clk,
    input  logic      reset,
    input  inst_t     inst,
    input  logic      inst_valid,
    output addr_t     pc,
    output logic      rd_wen,
    output reg_addr_t rd_addr,
    output word_t     rd_data
);

    decode_t dec;
    word_t   reg_rdata1;
    word_t   reg_rdata2;
    addr_t   next_pc;

    // ==================================================
    // Fetch, decode, register file, execute
    // ==================================================
    pc_reg u_pc_reg (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .next_pc    (next_pc),
        .pc         (pc)
    );

    idu u_idu (
        .inst       (inst),
        .pc         (pc),
        .reg_rdata1 (reg_rdata1),
        .reg_rdata2 (reg_rdata2),
        .dec        (dec)
    );

    regfile #(
        .REG_COUNT (REG_COUNT)
    ) u_regfile (
        .clk    (clk),
        .reset  (reset),
        .rs1    (inst[19:15]),
        .rs2    (inst[24:20]),
        .rdata1 (reg_rdata1),
        .rdata2 (reg_rdata2),
        .wen    (rd_wen),       // Already gated by inst_valid
        .waddr  (rd_addr),
        .wdata  (rd_data)
    );

    exu u_exu (
        .dec        (dec),
        .pc         (pc),
        .inst_valid (inst_valid),
        .rd_wen     (rd_wen),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .next_pc    (next_pc)
    );

endmodule

`default_nettype wire

/* rv_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_chk
    import rv_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  inst_valid,
    input logic  rd_wen,
    input addr_t pc
);

    int fails = 0;

    // ==================================================
    // Core properties
    // ==================================================
    a_wen_gated: assert property (@(posedge clk) disable iff (reset)
        !inst_valid |-> !rd_wen)
        else begin $error("rd_wen high while inst_valid low"); fails++; end

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00)
        else begin $error("pc not word aligned"); fails++; end

    a_pc_hold: assert property (@(posedge clk) disable iff (reset)
        !inst_valid |=> $stable(pc))                 // Stall keeps pc
        else begin $error("pc moved during a stall"); fails++; end

    a_pc_reset: assert property (@(posedge clk)
        reset |=> pc == '0)
        else begin $error("pc not zero after reset"); fails++; end

endmodule

bind rv_core rv_core_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .rd_wen     (rd_wen),
    .pc         (pc)
);

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // ==================================================
    // Widths
    // ==================================================
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t ZERO_WORD = 32'h0000_0000;

    // ==================================================
    // Opcodes and function codes
    // ==================================================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // ==================================================
    // Decode to execute
    // ==================================================
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        word_t     src1;
        word_t     src2;
        alu_op_t   alu_op;
        logic      jump;     // JAL or JALR
        logic      reg_wen;  // Before inst_valid gating
        reg_addr_t rd;
    } decode_t;

endpackage

`default_nettype wire

/* tb.f */
rv_pkg.sv
pc_reg.sv
idu.sv
regfile.sv
exu.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    localparam int MAX_CYCLES = 2000;    // Several times the directed sequence length

    logic      clk;
    logic      reset;
    inst_t     inst;
    logic      inst_valid;
    addr_t     pc;
    logic      rd_wen;
    reg_addr_t rd_addr;
    word_t     rd_data;

    word_t reg_model [32];
    addr_t pc_model;
    word_t lcg_state = 32'd4;
    int    errors = 0;
    int    cycle_count = 0;

    rv_core #(.REG_COUNT(32)) u_dut (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .inst_valid (inst_valid),
        .pc         (pc),
        .rd_wen     (rd_wen),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================
    // Encoders and reference arithmetic
    // ==================================================
    function word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t enc_j(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // alt picks SUB or SRA, as funct7 bit 5 does
    function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
        word_t res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: res = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // ==================================================
    // Drive and check
    // ==================================================
    task automatic check_val(string name, word_t exp, word_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic issue(inst_t w, logic exp_wen, reg_addr_t exp_rd, word_t exp_data,
                         addr_t exp_next);
        @(posedge clk);
        inst       <= w;
        inst_valid <= 1'b1;
        @(negedge clk);
        check_val("pc", pc_model, pc);
        check_val("rd_wen", 32'(exp_wen), 32'(rd_wen));
        if (exp_wen) begin
            check_val("rd_addr", 32'(exp_rd), 32'(rd_addr));
            check_val("rd_data", exp_data, rd_data);
        end
        if (exp_wen && exp_rd != 5'd0)
            reg_model[exp_rd] = exp_data;    // Committed at the coming edge
        pc_model = exp_next;
    endtask

    task automatic idle_cycles(int n);
        word_t r;
        for (int i = 0; i < n; i++) begin
            r = lcg_next();
            @(posedge clk);
            inst       <= enc_i(r[11:0], 5'd1, 3'd0, 5'd5, OPC_OP_IMM);
            inst_valid <= 1'b0;
            @(negedge clk);
            check_val("pc", pc_model, pc);
            check_val("rd_wen", 32'd0, 32'(rd_wen));
        end
    endtask

    task automatic exec_op_imm(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                               logic [11:0] imm);
        logic alt;
        alt = (f3 == 3'd5) && imm[10];
        issue(enc_i(imm, rs1, f3, rd, OPC_OP_IMM), 1'b1, rd,
              ref_alu(f3, alt, reg_model[rs1], sext12(imm)), pc_model + 32'd4);
    endtask

    task automatic exec_op_reg(logic [2:0] f3, logic alt, reg_addr_t rd, reg_addr_t rs1,
                               reg_addr_t rs2);
        issue(enc_r(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd), 1'b1, rd,
              ref_alu(f3, alt, reg_model[rs1], reg_model[rs2]), pc_model + 32'd4);
    endtask

    task automatic load_reg(reg_addr_t rd, word_t v);
        logic [19:0] upper;
        upper = v[31:12] + 20'(v[11]);      // ADDI sign extends the low part
        issue(enc_u(upper, rd, OPC_LUI), 1'b1, rd, {upper, 12'b0}, pc_model + 32'd4);
        exec_op_imm(3'd0, rd, rd, v[11:0]);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset_idle();
        idle_cycles(2);
        exec_op_imm(3'd0, 5'd6, 5'd13, 12'h000);     // Cleared register reads zero
        load_reg(5'd5, lcg_next());
        idle_cycles(3);
        exec_op_imm(3'd0, 5'd6, 5'd5, 12'h000);
    endtask

    task automatic test_upper();
        word_t r;
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            issue(enc_u(r[31:12], 5'(10 + i), OPC_LUI), 1'b1, 5'(10 + i),
                  {r[31:12], 12'b0}, pc_model + 32'd4);
            issue(enc_u(r[19:0], 5'(20 + i), OPC_AUIPC), 1'b1, 5'(20 + i),
                  pc_model + {r[19:0], 12'b0}, pc_model + 32'd4);
        end
    endtask

    task automatic test_op_imm();
        logic [2:0]  f3;
        logic [11:0] imm;
        word_t       r;
        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k < 9; k++) begin
                f3  = (k == 8) ? 3'd5 : 3'(k);   // Index 8 is SRAI
                r   = lcg_next();
                imm = r[11:0];
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm = {(k == 8) ? 7'b0100000 : 7'b0000000, r[4:0]};
                load_reg(5'd1, lcg_next());
                exec_op_imm(f3, 5'd2, 5'd1, imm);
            end
        end
        exec_op_imm(3'd3, 5'd2, 5'd1, 12'hfff);      // SLTIU against all ones
        exec_op_imm(3'd2, 5'd2, 5'd1, 12'h800);
    endtask

    task automatic test_op_reg();
        for (int round = 0; round < 3; round++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if (alt == 0 || f3 == 0 || f3 == 5) begin
                        load_reg(5'd3, lcg_next());
                        load_reg(5'd4, lcg_next());
                        exec_op_reg(3'(f3), 1'(alt), 5'd5, 5'd3, 5'd4);
                    end
                end
            end
        end
    endtask

    task automatic test_jumps();
        word_t       r;
        logic [20:0] off;
        logic [11:0] imm;
        r   = lcg_next();
        off = {11'b0, r[9:2], 2'b00} + 21'd4;
        issue(enc_j(off, 5'd10), 1'b1, 5'd10, pc_model + 32'd4,
              pc_model + {{11{off[20]}}, off});
        issue(enc_j(21'h1ffff8, 5'd11), 1'b1, 5'd11, pc_model + 32'd4,
              pc_model - 32'd8);                 // Backward jump
        for (int i = 0; i < 2; i++) begin
            r   = lcg_next();
            imm = {1'b0, r[24:16], 2'b01};       // Target bit 0 set before clearing
            load_reg(5'd7, {16'b0, r[15:2], 2'b00});
            issue(enc_i(imm, 5'd7, 3'd0, 5'(9 - 2 * i), OPC_JALR), 1'b1, 5'(9 - 2 * i),
                  pc_model + 32'd4, (reg_model[7] + sext12(imm)) & ~32'd1);
            exec_op_imm(3'd0, 5'd12, 5'(9 - 2 * i), 12'h000);
        end
    endtask

    task automatic test_x0_unsupported();
        load_reg(5'd1, lcg_next());
        exec_op_imm(3'd0, 5'd0, 5'd1, 12'h005);      // Port shows the write
        exec_op_imm(3'd0, 5'd8, 5'd0, 12'h000);
        exec_op_reg(3'd0, 1'b0, 5'd8, 5'd0, 5'd0);
        issue(32'h0000_2083, 1'b0, 5'd1, 32'd0, pc_model + 32'd4);   // LW x1
        issue(32'h0ff0_000f, 1'b0, 5'd0, 32'd0, pc_model + 32'd4);   // FENCE
        exec_op_imm(3'd0, 5'd9, 5'd1, 12'h000);
    endtask

    // ==================================================
    // Sequence and timeout
    // ==================================================
    initial begin
        reset      = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        pc_model   = '0;
        for (int i = 0; i < 32; i++)
            reg_model[i] = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_reset_idle();
        test_upper();
        test_op_imm();
        test_op_reg();
        test_jumps();
        test_x0_unsupported();
        @(posedge clk);
        inst_valid <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        errors += u_dut.u_chk.fails;
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", MAX_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
